// ==== logic/dotp_pkg.sv ====
`default_nettype none

package dotp_pkg;

	// q8.8 elements.
	localparam int data_w = 16;
	localparam int frac_w = 8;

	typedef logic signed [data_w-1:0] elem_t;

	localparam elem_t max_val = 16'h7fff;
	localparam elem_t min_val = 16'h8000;

	localparam int axi_addr_w = 12;
	localparam int axi_data_w = 32;

	localparam logic [axi_addr_w-1:0] reg_ctrl = 12'h000;
	localparam logic [axi_addr_w-1:0] reg_status = 12'h004;
	localparam logic [axi_addr_w-1:0] reg_result = 12'h008;
	localparam logic [axi_addr_w-1:0] vec_base = 12'h100;
	localparam logic [axi_addr_w-1:0] mat_base = 12'h200;

	localparam logic [1:0] resp_okay = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

endpackage

`default_nettype wire

// ==== logic/dotp_regs.sv ====
`default_nettype none

module dotp_regs #(
	parameter int LANES = 32
) (
	input wire clk,
	input wire reset,
	input wire [dotp_pkg::axi_addr_w-1:0] awaddr,
	input wire awvalid,
	output logic awready,
	input wire [dotp_pkg::axi_data_w-1:0] wdata,
	input wire wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input wire bready,
	input wire [dotp_pkg::axi_addr_w-1:0] araddr,
	input wire arvalid,
	output logic arready,
	output logic [dotp_pkg::axi_data_w-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input wire rready,
	output dotp_pkg::elem_t [LANES-1:0] vec,
	output dotp_pkg::elem_t [LANES-1:0] mat,
	output logic op_valid,
	input wire dotp_pkg::elem_t sum,
	input wire sum_valid
);

	localparam int idx_w = $clog2(LANES);

	logic wr_fire;
	logic rd_fire;
	logic wr_ctrl;
	logic wr_vec;
	logic wr_mat;
	logic start;
	logic busy;
	logic done;
	dotp_pkg::elem_t result;
	logic [idx_w-1:0] wr_idx;
	logic [idx_w-1:0] rd_idx;
	logic [dotp_pkg::axi_data_w-1:0] rd_data;
	logic [1:0] rd_resp;

	// word aligned and inside the element window at base.
	function automatic logic in_window(input logic [dotp_pkg::axi_addr_w-1:0] addr,
		input logic [dotp_pkg::axi_addr_w-1:0] base);
		return addr[1:0] == 2'b00 &&
			addr[dotp_pkg::axi_addr_w-1:idx_w+2] == base[dotp_pkg::axi_addr_w-1:idx_w+2];
	endfunction

	function automatic logic [dotp_pkg::axi_data_w-1:0] sext(input dotp_pkg::elem_t x);
		return {{(dotp_pkg::axi_data_w - dotp_pkg::data_w){x[dotp_pkg::data_w-1]}}, x};
	endfunction

	if (LANES < 2 || LANES > 64 || (LANES & (LANES - 1)) != 0) begin : g_lanes_check
		$error("dotp_regs: LANES must be a power of two from 2 to 64");
	end

	// one write in flight, held off while the response waits.
	assign wr_fire = awvalid && wvalid && !bvalid;
	assign awready = wr_fire;
	assign wready = wr_fire;
	assign rd_fire = arvalid && !rvalid;
	assign arready = rd_fire;

	assign wr_ctrl = awaddr == dotp_pkg::reg_ctrl;
	assign wr_vec = in_window(awaddr, dotp_pkg::vec_base);
	assign wr_mat = in_window(awaddr, dotp_pkg::mat_base);
	assign wr_idx = awaddr[idx_w+1:2];
	assign rd_idx = araddr[idx_w+1:2];

	// busy rises a cycle after the pulse, so op_valid counts as busy too.
	assign start = wr_fire && wr_ctrl && wdata[0] && !busy && !op_valid;

	always_ff @(posedge clk) begin
		if (!reset)
			bvalid <= 1'b0;
		else if (wr_fire)
			bvalid <= 1'b1;
		else if (bready)
			bvalid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (wr_fire)
			bresp <= (wr_ctrl || wr_vec || wr_mat) ? dotp_pkg::resp_okay : dotp_pkg::resp_slverr;
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			vec <= '0;
			mat <= '0;
		end else if (wr_fire) begin
			if (wr_vec)
				vec[wr_idx] <= wdata[dotp_pkg::data_w-1:0];
			if (wr_mat)
				mat[wr_idx] <= wdata[dotp_pkg::data_w-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			op_valid <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
		end else begin
			op_valid <= start;
			if (start)
				done <= 1'b0;
			else if (sum_valid)
				done <= 1'b1;
			if (op_valid)
				busy <= 1'b1;
			else if (sum_valid)
				busy <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset)
			result <= '0;
		else if (sum_valid)
			result <= sum;
	end

	// ctrl reads back as zero.
	always_comb begin
		rd_data = '0;
		rd_resp = dotp_pkg::resp_okay;
		if (in_window(araddr, dotp_pkg::vec_base))
			rd_data = sext(vec[rd_idx]);
		else if (in_window(araddr, dotp_pkg::mat_base))
			rd_data = sext(mat[rd_idx]);
		else if (araddr == dotp_pkg::reg_status)
			rd_data[1:0] = {done, busy || op_valid};
		else if (araddr == dotp_pkg::reg_result)
			rd_data = sext(result);
		else if (araddr != dotp_pkg::reg_ctrl)
			rd_resp = dotp_pkg::resp_slverr;
	end

	always_ff @(posedge clk) begin
		if (!reset)
			rvalid <= 1'b0;
		else if (rd_fire)
			rvalid <= 1'b1;
		else if (rready)
			rvalid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (rd_fire) begin
			rdata <= rd_data;
			rresp <= rd_resp;
		end
	end

endmodule

`default_nettype wire

// ==== logic/lane_mul.sv ====
`default_nettype none

module lane_mul (
	input wire clk,
	input wire reset,
	input wire dotp_pkg::elem_t a,
	input wire dotp_pkg::elem_t b,
	input wire in_valid,
	output dotp_pkg::elem_t prod,
	output logic prod_valid
);

	logic signed [2*dotp_pkg::data_w-1:0] full;
	logic signed [2*dotp_pkg::data_w-1:0] scaled;
	logic overflow;

	assign full = a * b;
	// arithmetic shift rounds toward minus infinity.
	assign scaled = full >>> dotp_pkg::frac_w;
	assign overflow = scaled[2*dotp_pkg::data_w-1:dotp_pkg::data_w-1] !=
		{(dotp_pkg::data_w + 1){scaled[2*dotp_pkg::data_w-1]}};

	always_ff @(posedge clk) begin
		if (!reset)
			prod_valid <= 1'b0;
		else
			prod_valid <= in_valid;
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			if (!overflow)
				prod <= scaled[dotp_pkg::data_w-1:0];
			else if (scaled[2*dotp_pkg::data_w-1])
				prod <= dotp_pkg::min_val;
			else
				prod <= dotp_pkg::max_val;
		end
	end

endmodule

`default_nettype wire

// ==== logic/adder_tree.sv ====
`default_nettype none

module adder_tree #(
	parameter int LANES = 32
) (
	input wire clk,
	input wire reset,
	input wire dotp_pkg::elem_t [LANES-1:0] prod,
	input wire in_valid,
	output dotp_pkg::elem_t sum,
	output logic sum_valid
);

	localparam int levels = $clog2(LANES);

	// all tree nodes, leaves first, then each level in turn. root is last.
	wire dotp_pkg::elem_t [2*LANES-2:0] node;
	logic [levels-1:0] vld;

	function automatic dotp_pkg::elem_t sat_add(input dotp_pkg::elem_t x,
		input dotp_pkg::elem_t y);
		logic signed [dotp_pkg::data_w:0] s;
		s = x + y;
		if (s[dotp_pkg::data_w] != s[dotp_pkg::data_w-1])
			return s[dotp_pkg::data_w] ? dotp_pkg::min_val : dotp_pkg::max_val;
		return s[dotp_pkg::data_w-1:0];
	endfunction

	assign node[LANES-1:0] = prod;

	for (genvar l = 0; l < levels; l++) begin : g_level
		localparam int n = LANES >> (l + 1);
		localparam int in_base = 2*LANES - ((2*LANES) >> l);
		localparam int out_base = in_base + 2*n;

		dotp_pkg::elem_t [n-1:0] q;

		// neighbours 2k and 2k+1.
		always_ff @(posedge clk) begin
			for (int k = 0; k < n; k++) begin
				q[k] <= sat_add(node[in_base + 2*k], node[in_base + 2*k + 1]);
			end
		end

		assign node[out_base +: n] = q;
	end

	always_ff @(posedge clk) begin
		if (!reset)
			vld <= '0;
		else
			vld <= (vld << 1) | levels'(in_valid);
	end

	assign sum = node[2*LANES-2];
	assign sum_valid = vld[levels-1];

endmodule

`default_nettype wire

// ==== logic/dotp_top.sv ====
`default_nettype none

module dotp_top #(
	parameter int LANES = 32
) (
	input wire clk,
	input wire reset,
	input wire [dotp_pkg::axi_addr_w-1:0] awaddr,
	input wire awvalid,
	output logic awready,
	input wire [dotp_pkg::axi_data_w-1:0] wdata,
	input wire wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input wire bready,
	input wire [dotp_pkg::axi_addr_w-1:0] araddr,
	input wire arvalid,
	output logic arready,
	output logic [dotp_pkg::axi_data_w-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input wire rready
);

	dotp_pkg::elem_t [LANES-1:0] vec;
	dotp_pkg::elem_t [LANES-1:0] mat;
	dotp_pkg::elem_t [LANES-1:0] prod;
	logic [LANES-1:0] prod_valid;
	logic op_valid;
	dotp_pkg::elem_t sum;
	logic sum_valid;

	dotp_regs #(
		.LANES(LANES)
	) i_regs (
		.clk(clk),
		.reset(reset),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.vec(vec),
		.mat(mat),
		.op_valid(op_valid),
		.sum(sum),
		.sum_valid(sum_valid)
	);

	for (genvar i = 0; i < LANES; i++) begin : g_lane
		lane_mul i_lane (
			.clk(clk),
			.reset(reset),
			.a(vec[i]),
			.b(mat[i]),
			.in_valid(op_valid),
			.prod(prod[i]),
			.prod_valid(prod_valid[i])
		);
	end

	// lanes run in lock step. lane 0 speaks for all.
	adder_tree #(
		.LANES(LANES)
	) i_tree (
		.clk(clk),
		.reset(reset),
		.prod(prod),
		.in_valid(prod_valid[0]),
		.sum(sum),
		.sum_valid(sum_valid)
	);

endmodule

`default_nettype wire

// ==== verification/clock_gen.sv ====
`default_nettype none

module clock_gen (
	output logic clk,
	output logic reset
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// low for four rising edges, released on a falling edge.
	initial begin
		reset = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b1;
	end

endmodule

`default_nettype wire

// ==== verification/dotp_checker.sv ====
`default_nettype none

module dotp_checker (
	input wire clk,
	input wire reset,
	input wire bvalid,
	input wire bready,
	input wire rvalid,
	input wire rready,
	input wire op_valid,
	input wire busy,
	input wire done,
	input wire sum_valid
);
	timeunit 1ns;
	timeprecision 1ps;

	// responses stay up until taken.
	a_bvalid_hold: assert property (@(posedge clk) disable iff (!reset)
		bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");

	a_rvalid_hold: assert property (@(posedge clk) disable iff (!reset)
		rvalid && !rready |=> rvalid)
		else $error("rvalid dropped before rready");

	a_no_start_busy: assert property (@(posedge clk) disable iff (!reset)
		!(op_valid && busy))
		else $error("op_valid raised while busy");

	a_done_follows: assert property (@(posedge clk) disable iff (!reset)
		sum_valid |=> done)
		else $error("done not set after sum_valid");

endmodule

`default_nettype wire

// ==== verification/dotp_scoreboard.sv ====
`default_nettype none

module dotp_scoreboard #(
	parameter int LANES = 32
) (
	input wire clk,
	input wire reset,
	input wire [dotp_pkg::axi_addr_w-1:0] awaddr,
	input wire awvalid,
	input wire awready,
	input wire [dotp_pkg::axi_data_w-1:0] wdata,
	input wire wvalid,
	input wire wready,
	input wire [1:0] bresp,
	input wire bvalid,
	input wire bready,
	input wire [dotp_pkg::axi_addr_w-1:0] araddr,
	input wire arvalid,
	input wire arready,
	input wire [dotp_pkg::axi_data_w-1:0] rdata,
	input wire [1:0] rresp,
	input wire rvalid,
	input wire rready,
	input wire sum_valid,
	output int errors
);
	timeunit 1ns;
	timeprecision 1ps;

	dotp_pkg::elem_t vec_m [LANES];
	dotp_pkg::elem_t mat_m [LANES];
	logic [dotp_pkg::axi_addr_w-1:0] wr_addr;
	logic [dotp_pkg::axi_addr_w-1:0] rd_addr;
	logic [1:0] exp_bresp;
	logic pending;
	logic done_seen;
	logic [15:0] pending_result;
	logic [15:0] exp_result;
	int starts;
	int finished;

	function automatic int clamp16(input longint x);
		if (x > 32767)
			return 32767;
		if (x < -32768)
			return -32768;
		return int'(x);
	endfunction

	// lane products, then pairs 2k and 2k+1 per level.
	function automatic logic [15:0] dot_ref();
		int node [LANES];
		int n;
		for (int i = 0; i < LANES; i++)
			node[i] = clamp16((longint'(vec_m[i]) * longint'(mat_m[i])) >>> dotp_pkg::frac_w);
		n = LANES;
		while (n > 1) begin
			n = n / 2;
			for (int k = 0; k < n; k++)
				node[k] = clamp16(longint'(node[2*k]) + longint'(node[2*k+1]));
		end
		return node[0][15:0];
	endfunction

	// element number at base, or -1 outside the window.
	function automatic int elem_index(input logic [dotp_pkg::axi_addr_w-1:0] a,
		input logic [dotp_pkg::axi_addr_w-1:0] base);
		int off;
		off = int'(a) - int'(base);
		if (a[1:0] != 2'b00 || off < 0 || off >= 4*LANES)
			return -1;
		return off / 4;
	endfunction

	function automatic logic [31:0] sign_extend(input logic [15:0] x);
		return {{16{x[15]}}, x};
	endfunction

	task automatic compare(input string name, input logic [dotp_pkg::axi_addr_w-1:0] addr,
		input logic [31:0] want, input logic [31:0] got);
		if (want !== got) begin
			$display("[ERROR] %s at 0x%03h: expected 0x%08h, got 0x%08h", name, addr, want, got);
			errors++;
		end
	endtask

	task automatic take_write();
		int vi;
		int mi;
		vi = elem_index(awaddr, dotp_pkg::vec_base);
		mi = elem_index(awaddr, dotp_pkg::mat_base);
		wr_addr = awaddr;
		if (vi >= 0)
			vec_m[vi] = wdata[15:0];
		if (mi >= 0)
			mat_m[mi] = wdata[15:0];
		if (vi >= 0 || mi >= 0 || awaddr == dotp_pkg::reg_ctrl)
			exp_bresp = dotp_pkg::resp_okay;
		else
			exp_bresp = dotp_pkg::resp_slverr;
		// a start while a result is pending is dropped.
		if (awaddr == dotp_pkg::reg_ctrl && wdata[0] && !pending) begin
			pending = 1'b1;
			pending_result = dot_ref();
			starts++;
		end
	endtask

	task automatic check_read();
		int vi;
		int mi;
		logic [31:0] want;
		logic mapped;
		vi = elem_index(rd_addr, dotp_pkg::vec_base);
		mi = elem_index(rd_addr, dotp_pkg::mat_base);
		want = '0;
		mapped = 1'b1;
		if (vi >= 0)
			want = sign_extend(vec_m[vi]);
		else if (mi >= 0)
			want = sign_extend(mat_m[mi]);
		else if (rd_addr == dotp_pkg::reg_result)
			want = sign_extend(exp_result);
		else if (rd_addr == dotp_pkg::reg_status) begin
			if (pending && rdata[1]) begin
				pending = 1'b0;
				done_seen = 1'b1;
				exp_result = pending_result;
			end
			want = pending ? 32'h1 : {30'b0, done_seen, 1'b0};
		end else if (rd_addr != dotp_pkg::reg_ctrl)
			mapped = 1'b0;
		compare("rresp", rd_addr,
			{30'b0, mapped ? dotp_pkg::resp_okay : dotp_pkg::resp_slverr}, {30'b0, rresp});
		compare("rdata", rd_addr, want, rdata);
	endtask

	always @(posedge clk) begin
		if (!reset) begin
			for (int i = 0; i < LANES; i++) begin
				vec_m[i] = '0;
				mat_m[i] = '0;
			end
			pending = 1'b0;
			done_seen = 1'b0;
			exp_result = '0;
			starts = 0;
			finished = 0;
		end else begin
			if (bvalid && bready)
				compare("bresp", wr_addr, {30'b0, exp_bresp}, {30'b0, bresp});
			if (awvalid && awready && wvalid && wready)
				take_write();
			if (rvalid && rready)
				check_read();
			if (arvalid && arready)
				rd_addr = araddr;
			if (sum_valid) begin
				finished++;
				if (finished > starts) begin
					$display("a computation finished that was never accepted as a start");
					errors++;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== verification/dotp_tb.sv ====
`default_nettype none

module dotp_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int LANES = 32;
	localparam int wait_limit = 50;
	localparam int poll_limit = 40;

	logic clk;
	logic reset;
	logic [dotp_pkg::axi_addr_w-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [dotp_pkg::axi_data_w-1:0] wdata;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [dotp_pkg::axi_addr_w-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [dotp_pkg::axi_data_w-1:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	int mismatches;
	int timeouts;
	integer seed;
	logic [31:0] word;

	clock_gen i_clk (
		.clk(clk),
		.reset(reset)
	);

	dotp_top #(
		.LANES(LANES)
	) i_dut (
		.clk(clk),
		.reset(reset),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready)
	);

	dotp_scoreboard #(
		.LANES(LANES)
	) i_sb (
		.clk(clk),
		.reset(reset),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.sum_valid(i_dut.sum_valid),
		.errors(mismatches)
	);

	bind dotp_regs dotp_checker i_checker (
		.clk(clk),
		.reset(reset),
		.bvalid(bvalid),
		.bready(bready),
		.rvalid(rvalid),
		.rready(rready),
		.op_valid(op_valid),
		.busy(busy),
		.done(done),
		.sum_valid(sum_valid)
	);

	task automatic report_timeout(input string what);
		$display("timeout while waiting for %s", what);
		timeouts++;
	endtask

	function automatic logic [dotp_pkg::axi_addr_w-1:0] elem_addr(
		input logic [dotp_pkg::axi_addr_w-1:0] base, input int i);
		return base + 12'(4 * i);
	endfunction

	// called and left on a falling edge.
	task automatic axi_write(input logic [dotp_pkg::axi_addr_w-1:0] addr,
		input logic [31:0] data);
		int cnt;
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		bready = 1'b1;
		cnt = 0;
		@(posedge clk);
		while (!(awready && wready) && cnt < wait_limit) begin
			cnt++;
			@(posedge clk);
		end
		if (!(awready && wready))
			report_timeout("awready and wready");
		@(negedge clk);
		awvalid = 1'b0;
		wvalid = 1'b0;
		cnt = 0;
		@(posedge clk);
		while (!bvalid && cnt < wait_limit) begin
			cnt++;
			@(posedge clk);
		end
		if (!bvalid)
			report_timeout("bvalid");
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [dotp_pkg::axi_addr_w-1:0] addr,
		output logic [31:0] data);
		int cnt;
		araddr = addr;
		arvalid = 1'b1;
		rready = 1'b1;
		data = '0;
		cnt = 0;
		@(posedge clk);
		while (!arready && cnt < wait_limit) begin
			cnt++;
			@(posedge clk);
		end
		if (!arready)
			report_timeout("arready");
		@(negedge clk);
		arvalid = 1'b0;
		cnt = 0;
		@(posedge clk);
		while (!rvalid && cnt < wait_limit) begin
			cnt++;
			@(posedge clk);
		end
		if (!rvalid)
			report_timeout("rvalid");
		else
			data = rdata;
		@(negedge clk);
		rready = 1'b0;
	endtask

	task automatic wait_done();
		logic [31:0] st;
		int cnt;
		st = '0;
		cnt = 0;
		while (!st[1] && cnt < poll_limit) begin
			axi_read(dotp_pkg::reg_status, st);
			cnt++;
		end
		if (!st[1])
			report_timeout("the done bit");
	endtask

	task automatic load_random(input int span);
		for (int i = 0; i < LANES; i++) begin
			axi_write(elem_addr(dotp_pkg::vec_base, i), $random(seed) % (span + 1));
			axi_write(elem_addr(dotp_pkg::mat_base, i), $random(seed) % (span + 1));
		end
	endtask

	task automatic load_const(input logic [31:0] v, input logic [31:0] m);
		for (int i = 0; i < LANES; i++) begin
			axi_write(elem_addr(dotp_pkg::vec_base, i), v);
			axi_write(elem_addr(dotp_pkg::mat_base, i), m);
		end
	endtask

	task automatic run_and_read();
		axi_write(dotp_pkg::reg_ctrl, 32'h1);
		wait_done();
		axi_read(dotp_pkg::reg_result, word);
	endtask

	initial begin
		int cnt;
		seed = 32'hcfef;
		timeouts = 0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		cnt = 0;
		while (reset !== 1'b1 && cnt < wait_limit) begin
			@(negedge clk);
			cnt++;
		end
		if (reset !== 1'b1)
			report_timeout("reset release");

		// state right after reset.
		axi_read(dotp_pkg::reg_status, word);
		axi_read(dotp_pkg::reg_result, word);
		axi_read(dotp_pkg::reg_ctrl, word);
		axi_read(elem_addr(dotp_pkg::vec_base, 0), word);
		axi_read(elem_addr(dotp_pkg::vec_base, LANES - 1), word);
		axi_read(elem_addr(dotp_pkg::mat_base, 0), word);
		axi_read(elem_addr(dotp_pkg::mat_base, LANES - 1), word);

		// within +-2.0 in q8.8.
		repeat (20) begin
			load_random(512);
			run_and_read();
		end

		// saturation both ways.
		load_const(32'h7f00, 32'h7f00);
		run_and_read();
		load_const(32'h7f00, 32'hffff8100);
		run_and_read();

		// upper half of each word is dropped.
		for (int i = 0; i < LANES; i++) begin
			axi_write(elem_addr(dotp_pkg::vec_base, i), $random(seed));
			axi_write(elem_addr(dotp_pkg::mat_base, i), $random(seed));
		end
		for (int i = 0; i < LANES; i++) begin
			axi_read(elem_addr(dotp_pkg::vec_base, i), word);
			axi_read(elem_addr(dotp_pkg::mat_base, i), word);
		end

		// illegal accesses.
		axi_write(12'h00c, 32'hdeadbeef);
		axi_write(12'h180, 32'h1234);
		axi_write(12'h300, 32'h5678);
		axi_write(12'h102, 32'h9abc);
		axi_write(dotp_pkg::reg_result, 32'h1);
		axi_write(dotp_pkg::reg_status, 32'h3);
		axi_read(12'h00c, word);
		axi_read(12'h180, word);
		axi_read(12'h300, word);
		axi_read(12'hffc, word);
		axi_read(12'h102, word);

		// second start lands while busy.
		load_random(512);
		axi_write(dotp_pkg::reg_ctrl, 32'h1);
		axi_write(dotp_pkg::vec_base, 32'h0100);
		axi_write(dotp_pkg::reg_ctrl, 32'h1);
		wait_done();
		axi_read(dotp_pkg::reg_result, word);
		repeat (12) @(negedge clk);
		axi_read(dotp_pkg::reg_status, word);
		axi_read(dotp_pkg::reg_result, word);

		@(negedge clk);
		$display("checks finished: %0d mismatches, %0d timeouts", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
logic/dotp_pkg.sv
logic/dotp_regs.sv
logic/lane_mul.sv
logic/adder_tree.sv
logic/dotp_top.sv
verification/clock_gen.sv
verification/dotp_checker.sv
verification/dotp_scoreboard.sv
verification/dotp_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the dot-product testbench with verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module dotp_tb -o dotp_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/dotp_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# the simulator's output decides the result.
if printf '%s\n' "$out" | grep -qx "SIMULATION PASSED"; then
	exit 0
fi
exit 1
